/* perf_cnt_top.f */
+incdir+include
hw/perf_cnt_pkg.sv
hw/perf_counters.sv
hw/perf_event_gate.sv
hw/perf_csr_decode.sv
hw/perf_cnt_top.sv
dv/tb_perf_cnt_top.sv

/* Bender.yml */
package:
  name: perf_cnt

export_include_dirs:
  - include

sources:
  - hw/perf_cnt_pkg.sv
  - hw/perf_counters.sv
  - hw/perf_event_gate.sv
  - hw/perf_csr_decode.sv
  - hw/perf_cnt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_perf_cnt_top.sv

/* dv/tb_perf_cnt_top.sv */
`timescale 1ns/1ps

`include "perf_cnt_macros.svh"

module tb_perf_cnt_top
  import perf_cnt_pkg::*;
();

  localparam logic [63:0] HpmMask = (64'd1 << `PERF_HPM_WIDTH) - 64'd1;

  logic       clk;
  logic       rst_ni;
  csr_req_t   csr_req;
  event_vec_t event_in;
  csr_data_t  csr_rdata;

  // Reference model of the readable state
  cnt_val_t   m_cnt [`PERF_NUM_CNT];
  event_sel_t m_sel [`PERF_NUM_CNT];
  cnt_vec_t   m_inh;

  csr_data_t   exp_rdata;
  logic        chk_en;
  logic        chk_narrow_hi;
  logic [31:0] lfsr;
  logic [31:0] rnd;

  perf_cnt_top u_perf_cnt_top (
    .clk_i       (clk),
    .rst_ni      (rst_ni),
    .csr_req_i   (csr_req),
    .event_i     (event_in),
    .csr_rdata_o (csr_rdata)
  );

  always #50 clk = ~clk;

  // Read data follows the model state of the cycle the address is applied
  assert property (@(posedge clk) chk_en |-> (csr_rdata == exp_rdata))
    else begin
      $display("** Error csr_rdata_o: expected 0x%h, actual 0x%h",
               $sampled(exp_rdata), $sampled(csr_rdata));
      $display("TESTBENCH FAILED");
      $fatal(1);
    end

  // High half of a programmable counter holds only 8 live bits
  assert property (@(posedge clk) chk_narrow_hi |-> (csr_rdata[31:`PERF_HPM_WIDTH-32] == '0))
    else begin
      $display("** Error csr_rdata_o: expected upper bits 0x0, actual 0x%h",
               $sampled(csr_rdata[31:`PERF_HPM_WIDTH-32]));
      $display("TESTBENCH FAILED");
      $fatal(1);
    end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic csr_data_t model_read(input csr_addr_t addr);
    csr_data_t r;
    r = '0;
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      if (addr == csr_addr_t'(`PERF_CSR_CNT_LO + i)) begin
        r = m_cnt[i][31:0];
      end
      if (addr == csr_addr_t'(`PERF_CSR_CNT_HI + i)) begin
        r = m_cnt[i][63:32];
      end
      if ((i >= 2) && (addr == csr_addr_t'(`PERF_CSR_EVENT + i))) begin
        r = csr_data_t'(m_sel[i]);
      end
    end
    if (addr == `PERF_CSR_INHIBIT) begin
      r = csr_data_t'(m_inh);
    end
    return r;
  endfunction

  // One clock of the model, writes win over the increment of that cycle
  task automatic model_step();
    cnt_vec_t inc;
    cnt_val_t nv;
    logic     wlo;
    logic     whi;
    inc = '0;
    inc[0] = 1'b1;
    inc[1] = event_in[0];
    for (int i = 2; i < `PERF_NUM_CNT; i++) begin
      if (m_sel[i] != '0) begin
        inc[i] = event_in[m_sel[i]];
      end
    end
    inc = inc & ~m_inh;
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      nv  = m_cnt[i];
      wlo = csr_req.we && (csr_req.addr == csr_addr_t'(`PERF_CSR_CNT_LO + i));
      whi = csr_req.we && (csr_req.addr == csr_addr_t'(`PERF_CSR_CNT_HI + i));
      if (wlo) begin
        nv[31:0] = csr_req.wdata;
      end
      if (whi) begin
        nv[63:32] = csr_req.wdata;
      end
      if (!wlo && !whi && inc[i]) begin
        nv = nv + 64'd1;
      end
      if (i >= 2) begin
        nv = nv & HpmMask;
      end
      m_cnt[i] = nv;
      if (csr_req.we && (i >= 2) && (csr_req.addr == csr_addr_t'(`PERF_CSR_EVENT + i))) begin
        m_sel[i] = csr_req.wdata[3:0];
      end
    end
    if (csr_req.we && (csr_req.addr == `PERF_CSR_INHIBIT)) begin
      m_inh = csr_req.wdata[`PERF_NUM_CNT-1:0];
    end
  endtask

  always @(posedge clk) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PERF_NUM_CNT; i++) begin
        m_cnt[i] = '0;
        m_sel[i] = '0;
      end
      m_inh = '0;
    end else begin
      model_step();
    end
  end

  // Applies one request 5 ns after the edge and returns at the next one plus 5 ns
  task automatic drive_cycle(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                             input event_vec_t ev);
    csr_req.we    = we;
    csr_req.addr  = addr;
    csr_req.wdata = wdata;
    event_in      = ev;
    exp_rdata     = model_read(addr);
    chk_en        = 1'b1;
    chk_narrow_hi = (addr >= csr_addr_t'(`PERF_CSR_CNT_HI + 2)) &&
                    (addr < csr_addr_t'(`PERF_CSR_CNT_HI + `PERF_NUM_CNT));
    @(posedge clk);
    #5;
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_data_t wdata, input event_vec_t ev);
    drive_cycle(1'b1, addr, wdata, ev);
  endtask

  task automatic csr_read(input csr_addr_t addr, input event_vec_t ev);
    drive_cycle(1'b0, addr, '0, ev);
  endtask

  task automatic read_random(input csr_addr_t addr, input int n);
    logic [31:0] ev;
    for (int k = 0; k < n; k++) begin
      rand_bits(`PERF_NUM_EVENTS, ev);
      csr_read(addr, ev[`PERF_NUM_EVENTS-1:0]);
    end
  endtask

  task automatic read_all(input event_vec_t ev);
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      csr_read(csr_addr_t'(`PERF_CSR_CNT_LO + i), ev);
      csr_read(csr_addr_t'(`PERF_CSR_CNT_HI + i), ev);
      if (i >= 2) begin
        csr_read(csr_addr_t'(`PERF_CSR_EVENT + i), ev);
      end
    end
    csr_read(`PERF_CSR_INHIBIT, ev);
  endtask

  task automatic wait_carry(input int idx, input csr_data_t old_hi, input event_vec_t ev);
    int n;
    n = 0;
    while ((m_cnt[idx][63:32] == old_hi) && (n < 64)) begin
      csr_read(csr_addr_t'(`PERF_CSR_CNT_HI + idx), ev);
      n++;
    end
    if (m_cnt[idx][63:32] == old_hi) begin
      $display("Timeout: the high half of counter %0d never took the carry", idx);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic wait_wrap(input int idx, input event_vec_t ev);
    int n;
    n = 0;
    while ((m_cnt[idx] >= (HpmMask & ~64'hFFFF_FFFF)) && (n < 64)) begin
      csr_read(csr_addr_t'(`PERF_CSR_CNT_LO + idx), ev);
      n++;
    end
    if (m_cnt[idx] >= (HpmMask & ~64'hFFFF_FFFF)) begin
      $display("Timeout: programmable counter %0d never wrapped to zero", idx);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic probe_unknown(input csr_addr_t addr);
    csr_write(addr, 32'hDEAD_BEEF, '0);
    csr_read(addr, '0);
  endtask

  initial begin
    clk           = 1'b0;
    rst_ni        = 1'b0;
    csr_req       = '0;
    event_in      = '0;
    exp_rdata     = '0;
    chk_en        = 1'b0;
    chk_narrow_hi = 1'b0;
    lfsr          = 32'd86487;
    repeat (8) @(posedge clk);
    #5;
    rst_ni = 1'b1;

    // Reset values
    read_all('0);

    // Cycle counter write, then carry into the high half
    csr_write(`PERF_CSR_CNT_LO, 32'h1000_0000, '0);
    read_random(`PERF_CSR_CNT_LO, 10);
    csr_write(`PERF_CSR_CNT_HI, 32'hFFFF_FFFF, '0);
    csr_write(`PERF_CSR_CNT_LO, 32'hFFFF_FFF0, '0);
    wait_carry(0, 32'hFFFF_FFFF, '0);
    csr_write(csr_addr_t'(`PERF_CSR_CNT_LO + 1), 32'hFFFF_FFFC, 16'h0001);
    wait_carry(1, 32'h0000_0000, 16'h0001);

    // Random nonzero selectors on the programmable counters
    for (int i = 2; i < `PERF_NUM_CNT; i++) begin
      rand_bits(4, rnd);
      if (rnd[3:0] == 4'd0) begin
        rnd = 32'd1;
      end
      csr_write(csr_addr_t'(`PERF_CSR_EVENT + i), rnd, '0);
    end
    for (int i = 2; i < `PERF_NUM_CNT; i++) begin
      read_random(csr_addr_t'(`PERF_CSR_CNT_LO + i), 8);
    end
    read_all('0);

    // Selector zero freezes counter 7
    csr_write(csr_addr_t'(`PERF_CSR_EVENT + 7), 32'd0, '0);
    read_random(csr_addr_t'(`PERF_CSR_CNT_LO + 7), 12);

    // Narrow width on the high half and the wrap at 2^40
    csr_write(csr_addr_t'(`PERF_CSR_CNT_HI + 3), 32'hFFFF_FFFF, '0);
    csr_read(csr_addr_t'(`PERF_CSR_CNT_HI + 3), '0);
    csr_write(csr_addr_t'(`PERF_CSR_EVENT + 2), 32'd5, '0);
    csr_write(csr_addr_t'(`PERF_CSR_CNT_HI + 2), 32'h0000_00FF, 16'h0020);
    csr_write(csr_addr_t'(`PERF_CSR_CNT_LO + 2), 32'hFFFF_FFF8, 16'h0020);
    wait_wrap(2, 16'h0020);
    csr_read(csr_addr_t'(`PERF_CSR_CNT_HI + 2), 16'h0020);

    // Inhibit counters 0 and 2, the rest keep going
    csr_write(`PERF_CSR_INHIBIT, 32'h0000_0005, 16'h0021);
    csr_read(`PERF_CSR_INHIBIT, 16'h0021);
    for (int i = 0; i < 4; i++) begin
      read_random(csr_addr_t'(`PERF_CSR_CNT_LO + i), 6);
    end
    csr_write(`PERF_CSR_INHIBIT, 32'd0, '0);
    read_random(`PERF_CSR_CNT_LO, 4);

    // Write on the same cycle as a retired instruction
    csr_write(csr_addr_t'(`PERF_CSR_CNT_LO + 1), 32'h1234_5678, 16'h0001);
    csr_read(csr_addr_t'(`PERF_CSR_CNT_LO + 1), '0);

    // Unknown addresses
    probe_unknown(12'h321);
    probe_unknown(12'h328);
    probe_unknown(12'hB08);
    probe_unknown(12'hB88);
    probe_unknown(12'h000);
    probe_unknown(12'hFFF);
    read_all('0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* hw/perf_cnt_top.sv */
`timescale 1ns/1ps

`include "perf_cnt_macros.svh"

module perf_cnt_top
  import perf_cnt_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  csr_req_t   csr_req_i,
  input  event_vec_t event_i,
  output csr_data_t  csr_rdata_o
);

  cnt_vec_t   cnt_we_lo;
  cnt_vec_t   cnt_we_hi;
  cnt_vec_t   sel_we;
  logic       inhibit_we;
  csr_data_t  wdata;
  cnt_vec_t   cnt_inc;
  cnt_vec_t   inhibit;
  cnt_val_t   cnt_val [`PERF_NUM_CNT];
  event_sel_t event_sel [`PERF_NUM_CNT];

  perf_csr_decode u_perf_csr_decode (
    .csr_req_i    (csr_req_i),
    .cnt_val_i    (cnt_val),
    .event_sel_i  (event_sel),
    .inhibit_i    (inhibit),
    .cnt_we_lo_o  (cnt_we_lo),
    .cnt_we_hi_o  (cnt_we_hi),
    .sel_we_o     (sel_we),
    .inhibit_we_o (inhibit_we),
    .wdata_o      (wdata),
    .csr_rdata_o  (csr_rdata_o)
  );

  perf_event_gate u_perf_event_gate (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .event_i      (event_i),
    .sel_we_i     (sel_we),
    .inhibit_we_i (inhibit_we),
    .wdata_i      (wdata),
    .event_sel_o  (event_sel),
    .inhibit_o    (inhibit),
    .cnt_inc_o    (cnt_inc)
  );

  perf_counters #(
    .NumCounters (`PERF_NUM_CNT),
    .HpmWidth    (`PERF_HPM_WIDTH)
  ) u_perf_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cnt_inc_i   (cnt_inc),
    .cnt_we_lo_i (cnt_we_lo),
    .cnt_we_hi_i (cnt_we_hi),
    .wdata_i     (wdata),
    .cnt_val_o   (cnt_val)
  );

endmodule

/* hw/perf_csr_decode.sv */
`timescale 1ns/1ps

`include "perf_cnt_macros.svh"

module perf_csr_decode
  import perf_cnt_pkg::*;
(
  input  csr_req_t   csr_req_i,
  input  cnt_val_t   cnt_val_i [`PERF_NUM_CNT],
  input  event_sel_t event_sel_i [`PERF_NUM_CNT],
  input  cnt_vec_t   inhibit_i,
  output cnt_vec_t   cnt_we_lo_o,
  output cnt_vec_t   cnt_we_hi_o,
  output cnt_vec_t   sel_we_o,
  output logic       inhibit_we_o,
  output csr_data_t  wdata_o,
  output csr_data_t  csr_rdata_o
);

  cnt_vec_t hit_lo;
  cnt_vec_t hit_hi;
  cnt_vec_t hit_sel;
  logic     hit_inhibit;

  // Address match per register
  always_comb begin
    hit_lo  = '0;
    hit_hi  = '0;
    hit_sel = '0;
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      hit_lo[i] = (csr_req_i.addr == csr_addr_t'(`PERF_CSR_CNT_LO + i));
      hit_hi[i] = (csr_req_i.addr == csr_addr_t'(`PERF_CSR_CNT_HI + i));
      // Only the programmable counters have a selector
      if (i >= 2) begin
        hit_sel[i] = (csr_req_i.addr == csr_addr_t'(`PERF_CSR_EVENT + i));
      end
    end
    hit_inhibit = (csr_req_i.addr == `PERF_CSR_INHIBIT);
  end

  // Write strobes
  assign cnt_we_lo_o  = csr_req_i.we ? hit_lo : '0;
  assign cnt_we_hi_o  = csr_req_i.we ? hit_hi : '0;
  assign sel_we_o     = csr_req_i.we ? hit_sel : '0;
  assign inhibit_we_o = csr_req_i.we & hit_inhibit;
  assign wdata_o      = csr_req_i.wdata;

  // Read mux, unknown addresses give zero
  always_comb begin
    csr_rdata_o = '0;
    for (int i = 0; i < `PERF_NUM_CNT; i++) begin
      if (hit_lo[i]) begin
        csr_rdata_o = cnt_val_i[i][31:0];
      end
      if (hit_hi[i]) begin
        csr_rdata_o = cnt_val_i[i][63:32];
      end
      if (hit_sel[i]) begin
        csr_rdata_o = csr_data_t'(event_sel_i[i]);
      end
    end
    if (hit_inhibit) begin
      csr_rdata_o = csr_data_t'(inhibit_i);
    end
  end

  // Address ranges must not overlap
  always_comb begin
    assert final ($onehot0({cnt_we_lo_o, cnt_we_hi_o, sel_we_o, inhibit_we_o}))
      else $error("perf_csr_decode: more than one write strobe at 0x%h", csr_req_i.addr);
  end

endmodule

/* hw/perf_event_gate.sv */
`timescale 1ns/1ps

`include "perf_cnt_macros.svh"

module perf_event_gate
  import perf_cnt_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  event_vec_t event_i,
  input  cnt_vec_t   sel_we_i,
  input  logic       inhibit_we_i,
  input  csr_data_t  wdata_i,
  output event_sel_t event_sel_o [`PERF_NUM_CNT],
  output cnt_vec_t   inhibit_o,
  output cnt_vec_t   cnt_inc_o
);

  cnt_vec_t   inhibit_q;
  event_sel_t sel_q [`PERF_NUM_CNT];
  cnt_vec_t   cnt_src;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (inhibit_we_i) begin
      inhibit_q <= wdata_i[`PERF_NUM_CNT-1:0];
    end
  end

  for (genvar i = 0; i < `PERF_NUM_CNT; i++) begin : g_sel
    if (i < 2) begin : g_fixed
      // Fixed counters have no selector
      assign sel_q[i] = '0;
    end else begin : g_prog
      always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
          sel_q[i] <= '0;
        end else if (sel_we_i[i]) begin
          sel_q[i] <= wdata_i[$bits(event_sel_t)-1:0];
        end
      end
    end
  end

  // Per-counter event source
  always_comb begin
    cnt_src    = '0;
    cnt_src[0] = 1'b1;
    cnt_src[1] = event_i[0];
    for (int i = 2; i < `PERF_NUM_CNT; i++) begin
      // Selector 0 means no event
      if (sel_q[i] != '0) begin
        cnt_src[i] = event_i[sel_q[i]];
      end
    end
  end

  assign cnt_inc_o   = cnt_src & ~inhibit_q;
  assign inhibit_o   = inhibit_q;
  assign event_sel_o = sel_q;

  // Newly inhibited counters stop from the next cycle on
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    inhibit_we_i |=> ((cnt_inc_o & $past(wdata_i[`PERF_NUM_CNT-1:0])) == '0))
    else $error("perf_event_gate: increment on an inhibited counter");

endmodule

/* hw/perf_counters.sv */
`timescale 1ns/1ps

`include "perf_cnt_macros.svh"

module perf_counters
  import perf_cnt_pkg::*;
#(
  parameter int NumCounters = `PERF_NUM_CNT,
  parameter int HpmWidth    = `PERF_HPM_WIDTH
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  cnt_vec_t  cnt_inc_i,
  input  cnt_vec_t  cnt_we_lo_i,
  input  cnt_vec_t  cnt_we_hi_i,
  input  csr_data_t wdata_i,
  output cnt_val_t  cnt_val_o [`PERF_NUM_CNT]
);

  cnt_val_t cnt_val [`PERF_NUM_CNT];

  assign cnt_val_o = cnt_val;

  for (genvar i = 0; i < `PERF_NUM_CNT; i++) begin : g_cnt
    if (i < NumCounters) begin : g_impl
      // Cycle and retired counters keep the full 64 bits
      localparam int Width = (i < 2) ? `PERF_CNT_WIDTH : HpmWidth;

      logic [Width-1:0] cnt_q;
      logic [Width-1:0] cnt_d;
      cnt_val_t         cnt_load;
      cnt_val_t         cnt_upd;

      always_comb begin
        // Merge the written half into the current value
        cnt_load = cnt_val[i];
        if (cnt_we_lo_i[i]) begin
          cnt_load[31:0] = wdata_i;
        end
        if (cnt_we_hi_i[i]) begin
          cnt_load[63:32] = wdata_i;
        end

        cnt_upd = cnt_val[i] + 64'd1;

        // A write drops the increment of the same cycle
        if (cnt_we_lo_i[i] || cnt_we_hi_i[i]) begin
          cnt_d = cnt_load[Width-1:0];
        end else if (cnt_inc_i[i]) begin
          cnt_d = cnt_upd[Width-1:0];
        end else begin
          cnt_d = cnt_q;
        end
      end

      always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_d;
        end
      end

      if (Width < `PERF_CNT_WIDTH) begin : g_narrow
        assign cnt_val[i][Width-1:0]                 = cnt_q;
        assign cnt_val[i][`PERF_CNT_WIDTH-1:Width]   = '0;

        // Wrap from all ones lands on zero, nothing leaks above the width
        assert property (@(posedge clk_i) disable iff (!rst_ni)
          (cnt_inc_i[i] && !cnt_we_lo_i[i] && !cnt_we_hi_i[i] && (&cnt_q))
          |=> (cnt_val[i] == '0))
          else $error("perf_counters: counter %0d did not wrap to zero", i);
      end else begin : g_full
        assign cnt_val[i] = cnt_q;
      end
    end else begin : g_absent
      assign cnt_val[i] = '0;
    end
  end

endmodule

/* hw/perf_cnt_pkg.sv */
`include "perf_cnt_macros.svh"

package perf_cnt_pkg;

  // CSR address and data words
  typedef logic [`PERF_CSR_ADDR_WIDTH-1:0] csr_addr_t;
  typedef logic [`PERF_CSR_DATA_WIDTH-1:0] csr_data_t;

  // Full counter value, narrow counters read with zero upper bits
  typedef logic [`PERF_CNT_WIDTH-1:0] cnt_val_t;

  // One bit per counter
  typedef logic [`PERF_NUM_CNT-1:0] cnt_vec_t;

  // One bit per raw event
  typedef logic [`PERF_NUM_EVENTS-1:0] event_vec_t;

  // Event index, 0 selects nothing
  typedef logic [`PERF_EVENT_SEL_WIDTH-1:0] event_sel_t;

  // Single-cycle CSR request
  typedef struct packed {
    logic      we;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

endpackage

/* include/perf_cnt_macros.svh */
`ifndef PERF_CNT_MACROS_SVH
`define PERF_CNT_MACROS_SVH

// Counter bank shape
`define PERF_NUM_CNT          8
`define PERF_CNT_WIDTH        64
`define PERF_HPM_WIDTH        40

// Raw core events, bit 0 is instruction retired
`define PERF_NUM_EVENTS       16
`define PERF_EVENT_SEL_WIDTH  4

// CSR port widths
`define PERF_CSR_ADDR_WIDTH   12
`define PERF_CSR_DATA_WIDTH   32

// CSR base addresses
`define PERF_CSR_CNT_LO       12'hB00
`define PERF_CSR_CNT_HI       12'hB80
`define PERF_CSR_EVENT        12'h320
`define PERF_CSR_INHIBIT      12'h320

`endif
